// ==== logic/lsu_defs.svh ====
/*
 * Sizing for the load/store path.
 * LSU_CREDITS must match the arbiter buffer depth per master.
 * LSU_THREADS must stay at 4 because the thread id is two bits wide.
 */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// word address carried on the bus
`define LSU_ADDR_W 12

// data memory depth in 32-bit words
`define LSU_MEM_WORDS 1024

// request slots reserved per master in the arbiter
`define LSU_CREDITS 2

// threads per core
`define LSU_THREADS 4

`endif

// ==== logic/lsu_pkg.sv ====
/*
 * Bus and core side payload types for the load/store path.
 * All addresses are word addresses. The masks select bytes.
 */
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

    typedef logic master_id_t;
    typedef logic [1:0] thread_id_t;

    // ******************************
    // bus side
    // ******************************

    typedef struct packed {
        master_id_t              master;
        thread_id_t              thread;
        logic                    wr;
        logic [3:0]              mask;
        logic [`LSU_ADDR_W-1:0]  addr;
        logic [31:0]             wdata;
    } bus_req_t;

    // write responses carry no useful rdata
    typedef struct packed {
        master_id_t  master;
        thread_id_t  thread;
        logic        wr;
        logic [3:0]  mask;
        logic [31:0] rdata;
    } bus_rsp_t;

    // ******************************
    // core side
    // ******************************

    typedef struct packed {
        thread_id_t              thread;
        logic                    wr;
        logic [3:0]              mask;
        logic [`LSU_ADDR_W-1:0]  addr;
        logic [31:0]             wdata;
        logic [3:0]              wb_reg;
    } core_req_t;

    typedef struct packed {
        thread_id_t  thread;
        logic [3:0]  wb_reg;
        logic [31:0] data;
    } load_ret_t;

endpackage

`default_nettype wire

// ==== logic/credit_fifo.sv ====
/*
 * Small circular buffer. There is no full flag because the sender's credits
 * guarantee a free slot. Do not pop while empty.
 * pop_data shows the head entry without a cycle of delay.
 */
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      pop_data,
    output logic          empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           slots [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    // storage, no reset needed
    always_ff @(posedge clk)
    begin
        if (push)
            slots[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign pop_data = slots[rd_ptr];
    assign empty    = (count == '0);

endmodule

`default_nettype wire

// ==== logic/lsu_thread_port.sv ====
/*
 * One core's port onto the shared memory bus.
 * The core must hold a request until issue_ready is high and its thread is
 * not stalled. Loads are zero-extended, never sign-extended.
 */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_thread_port #(
    parameter lsu_pkg::master_id_t MASTER_ID = 1'b0
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire lsu_pkg::core_req_t  core_req,
    input  wire logic                issue,
    output logic                     issue_ready,
    output logic [`LSU_THREADS-1:0]  stall,
    output lsu_pkg::bus_req_t        req,
    output logic                     req_vld,
    input  wire logic                credit_ret,
    input  wire lsu_pkg::bus_rsp_t   rsp,
    input  wire logic                rsp_vld,
    output lsu_pkg::load_ret_t       load_ret,
    output logic                     load_vld
);

    localparam int CRED_W = $clog2(`LSU_CREDITS + 1);

    logic [CRED_W-1:0]        credits;
    logic                     issue_ok;
    logic                     rsp_hit;
    logic [`LSU_THREADS-1:0]  set_mask;
    logic [`LSU_THREADS-1:0]  clr_mask;
    logic [3:0]               wb_table [`LSU_THREADS];
    lsu_pkg::bus_rsp_t        rsp_q;
    logic                     rsp_empty;
    logic [31:0]              aligned;

    // ******************************
    // request path
    // ******************************

    assign issue_ready = (credits != '0);
    assign issue_ok    = issue && issue_ready && !stall[core_req.thread];

    // passes straight through, the arbiter buffer registers it
    assign req_vld     = issue_ok;
    assign req.master  = MASTER_ID;
    assign req.thread  = core_req.thread;
    assign req.wr      = core_req.wr;
    assign req.mask    = core_req.mask;
    assign req.addr    = core_req.addr;
    assign req.wdata   = core_req.wdata;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            credits <= CRED_W'(`LSU_CREDITS);
        else if (issue_ok && !credit_ret)
            credits <= credits - 1'b1;
        else if (credit_ret && !issue_ok)
            credits <= credits + 1'b1;
    end

    // ******************************
    // thread stalls
    // ******************************

    assign rsp_hit = rsp_vld && (rsp.master == MASTER_ID);

    always_comb
    begin
        set_mask = '0;
        clr_mask = '0;
        if (issue_ok)
            set_mask[core_req.thread] = 1'b1;
        if (rsp_hit)
            clr_mask[rsp.thread] = 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            stall <= '0;
        else
            stall <= (stall | set_mask) & ~clr_mask;
    end

    // destination register per thread
    always_ff @(posedge clk)
    begin
        if (issue_ok)
            wb_table[core_req.thread] <= core_req.wb_reg;
    end

    // ******************************
    // retire
    // ******************************

    credit_fifo #(
        .payload_t (lsu_pkg::bus_rsp_t),
        .DEPTH     (1)
    ) rsp_buf (
        .clk       (clk),
        .rst       (rst),
        .push      (rsp_hit),
        .push_data (rsp),
        .pop       (!rsp_empty),
        .pop_data  (rsp_q),
        .empty     (rsp_empty)
    );

    // right-align the lanes picked by the mask
    always_comb
    begin
        case (rsp_q.mask)
            4'b1111: aligned = rsp_q.rdata;
            4'b1100: aligned = {16'd0, rsp_q.rdata[31:16]};
            4'b0011: aligned = {16'd0, rsp_q.rdata[15:0]};
            4'b1000: aligned = {24'd0, rsp_q.rdata[31:24]};
            4'b0100: aligned = {24'd0, rsp_q.rdata[23:16]};
            4'b0010: aligned = {24'd0, rsp_q.rdata[15:8]};
            default: aligned = {24'd0, rsp_q.rdata[7:0]};
        endcase
    end

    // write responses only clear the stall and are dropped here
    assign load_vld        = !rsp_empty && !rsp_q.wr;
    assign load_ret.thread = rsp_q.thread;
    assign load_ret.wb_reg = wb_table[rsp_q.thread];
    assign load_ret.data   = aligned;

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
/*
 * Two-master round-robin arbiter in front of the data memory.
 * Each master owns LSU_CREDITS buffer slots. The grant is registered,
 * so mem_vld comes one cycle after the pop.
 */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module mem_arbiter (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire lsu_pkg::bus_req_t  req_a,
    input  wire logic               req_a_vld,
    input  wire lsu_pkg::bus_req_t  req_b,
    input  wire logic               req_b_vld,
    output logic                    credit_ret_a,
    output logic                    credit_ret_b,
    output lsu_pkg::bus_req_t       mem_req,
    output logic                    mem_vld
);

    lsu_pkg::bus_req_t  head_a;
    lsu_pkg::bus_req_t  head_b;
    logic               empty_a;
    logic               empty_b;
    logic               grant_any;
    logic               pick_b;
    logic               last_b;

    credit_fifo #(
        .payload_t (lsu_pkg::bus_req_t),
        .DEPTH     (`LSU_CREDITS)
    ) buf_a (
        .clk       (clk),
        .rst       (rst),
        .push      (req_a_vld),
        .push_data (req_a),
        .pop       (credit_ret_a),
        .pop_data  (head_a),
        .empty     (empty_a)
    );

    credit_fifo #(
        .payload_t (lsu_pkg::bus_req_t),
        .DEPTH     (`LSU_CREDITS)
    ) buf_b (
        .clk       (clk),
        .rst       (rst),
        .push      (req_b_vld),
        .push_data (req_b),
        .pop       (credit_ret_b),
        .pop_data  (head_b),
        .empty     (empty_b)
    );

    // ******************************
    // round robin
    // ******************************

    // b wins when a is idle or a had the last grant
    assign grant_any    = !empty_a || !empty_b;
    assign pick_b       = !empty_b && (empty_a || !last_b);
    assign credit_ret_a = grant_any && !pick_b;
    assign credit_ret_b = pick_b;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_b  <= 1'b0;
            mem_vld <= 1'b0;
        end
        else
        begin
            mem_vld <= grant_any;
            if (grant_any)
                last_b <= pick_b;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_req <= pick_b ? head_b : head_a;
    end

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
/*
 * Single-port data memory, one access per cycle.
 * Only the low address bits index the array, the rest are ignored.
 * Every access, read or write, gets exactly one response.
 */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module data_mem (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire lsu_pkg::bus_req_t  mem_req,
    input  wire logic               mem_vld,
    output lsu_pkg::bus_rsp_t       rsp,
    output logic                    rsp_vld
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    logic [31:0]       words [`LSU_MEM_WORDS];
    logic [IDX_W-1:0]  idx;

    assign idx = mem_req.addr[IDX_W-1:0];

    // byte lane writes
    always_ff @(posedge clk)
    begin
        if (mem_vld && mem_req.wr)
        begin
            for (int i = 0; i < 4; i++)
                if (mem_req.mask[i])
                    words[idx][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
        end
    end

    // response echoes the request tags, rdata is the old word
    always_ff @(posedge clk)
    begin
        rsp.master <= mem_req.master;
        rsp.thread <= mem_req.thread;
        rsp.wr     <= mem_req.wr;
        rsp.mask   <= mem_req.mask;
        rsp.rdata  <= words[idx];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rsp_vld <= 1'b0;
        else
            rsp_vld <= mem_vld;
    end

endmodule

`default_nettype wire

// ==== logic/lsu_subsystem.sv ====
/*
 * Two core ports sharing one data memory.
 * Core a is master 0 and core b is master 1.
 */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_subsystem (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire lsu_pkg::core_req_t  core_req_a,
    input  wire logic                issue_a,
    output logic                     issue_ready_a,
    output logic [`LSU_THREADS-1:0]  stall_a,
    output lsu_pkg::load_ret_t       load_ret_a,
    output logic                     load_vld_a,
    input  wire lsu_pkg::core_req_t  core_req_b,
    input  wire logic                issue_b,
    output logic                     issue_ready_b,
    output logic [`LSU_THREADS-1:0]  stall_b,
    output lsu_pkg::load_ret_t       load_ret_b,
    output logic                     load_vld_b
);

    lsu_pkg::bus_req_t  req_a;
    lsu_pkg::bus_req_t  req_b;
    lsu_pkg::bus_req_t  mem_req;
    lsu_pkg::bus_rsp_t  rsp;
    logic               req_a_vld;
    logic               req_b_vld;
    logic               credit_ret_a;
    logic               credit_ret_b;
    logic               mem_vld;
    logic               rsp_vld;

    lsu_thread_port #(
        .MASTER_ID (1'b0)
    ) port_a (
        .clk         (clk),
        .rst         (rst),
        .core_req    (core_req_a),
        .issue       (issue_a),
        .issue_ready (issue_ready_a),
        .stall       (stall_a),
        .req         (req_a),
        .req_vld     (req_a_vld),
        .credit_ret  (credit_ret_a),
        .rsp         (rsp),
        .rsp_vld     (rsp_vld),
        .load_ret    (load_ret_a),
        .load_vld    (load_vld_a)
    );

    lsu_thread_port #(
        .MASTER_ID (1'b1)
    ) port_b (
        .clk         (clk),
        .rst         (rst),
        .core_req    (core_req_b),
        .issue       (issue_b),
        .issue_ready (issue_ready_b),
        .stall       (stall_b),
        .req         (req_b),
        .req_vld     (req_b_vld),
        .credit_ret  (credit_ret_b),
        .rsp         (rsp),
        .rsp_vld     (rsp_vld),
        .load_ret    (load_ret_b),
        .load_vld    (load_vld_b)
    );

    mem_arbiter arb (
        .clk          (clk),
        .rst          (rst),
        .req_a        (req_a),
        .req_a_vld    (req_a_vld),
        .req_b        (req_b),
        .req_b_vld    (req_b_vld),
        .credit_ret_a (credit_ret_a),
        .credit_ret_b (credit_ret_b),
        .mem_req      (mem_req),
        .mem_vld      (mem_vld)
    );

    // responses go to both ports, each filters on master
    data_mem mem (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_vld (mem_vld),
        .rsp     (rsp),
        .rsp_vld (rsp_vld)
    );

endmodule

`default_nettype wire

// ==== sim/lsu_assert.sv ====
/*
 * Checks bound into each thread port and into the arbiter.
 * Each binding ties off the ports that do not apply to it.
 */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_assert #(
    parameter int CRED_W = $clog2(`LSU_CREDITS + 1)
) (
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic [CRED_W-1:0]        credits,
    input wire logic [`LSU_THREADS-1:0]  stall,
    input wire logic                     rsp_hit,
    input wire lsu_pkg::thread_id_t      rsp_thread,
    input wire logic                     grant_vld,
    input wire logic                     empty_a,
    input wire logic                     empty_b,
    input wire logic                     pop_a,
    input wire logic                     pop_b
);

    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= CRED_W'(`LSU_CREDITS))
        else $error("credit count above its limit");

    // a stall bit only drops on its own thread's response
    for (genvar t = 0; t < `LSU_THREADS; t++)
    begin : g_thread
        stall_cleared_by_rsp: assert property (@(posedge clk) disable iff (rst)
            $fell(stall[t]) |-> $past(rsp_hit && rsp_thread == t))
            else $error("stall bit %0d cleared without a response", t);
    end

    // every grant comes from a pop of a buffer that held a request
    grant_needs_request: assert property (@(posedge clk) disable iff (rst)
        grant_vld |-> $past((pop_a && !empty_a) || (pop_b && !empty_b)))
        else $error("mem_vld without a buffered request");

    // a master that was just served yields to a waiting peer
    rr_yields_to_b: assert property (@(posedge clk) disable iff (rst)
        (pop_a && !empty_b) |=> pop_b)
        else $error("master b skipped while waiting");

    rr_yields_to_a: assert property (@(posedge clk) disable iff (rst)
        (pop_b && !empty_a) |=> pop_a)
        else $error("master a skipped while waiting");

endmodule

bind lsu_thread_port lsu_assert port_chk (
    .clk        (clk),
    .rst        (rst),
    .credits    (credits),
    .stall      (stall),
    .rsp_hit    (rsp_hit),
    .rsp_thread (rsp.thread),
    .grant_vld  (1'b0),
    .empty_a    (1'b1),
    .empty_b    (1'b1),
    .pop_a      (1'b0),
    .pop_b      (1'b0)
);

bind mem_arbiter lsu_assert arb_chk (
    .clk        (clk),
    .rst        (rst),
    .credits    ('0),
    .stall      ('0),
    .rsp_hit    (1'b0),
    .rsp_thread ('0),
    .grant_vld  (mem_vld),
    .empty_a    (empty_a),
    .empty_b    (empty_b),
    .pop_a      (credit_ret_a),
    .pop_b      (credit_ret_b)
);

`default_nettype wire

// ==== sim/lsu_tb.sv ====
/*
 * Testbench for the two-port load/store subsystem.
 * Core a owns word addresses with bit 9 clear, core b those with it set,
 * so the cores never share an address. Loads only read written words.
 */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defs.svh"

module lsu_tb;

    typedef struct packed {
        logic        core;
        logic [1:0]  thread;
        logic        wr;
        logic [3:0]  mask;
        logic [1:0]  slot;
        logic [3:0]  wb_reg;
    } row_t;

    localparam int NUM_ROWS        = 20;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 100;

    // core, thread, wr, mask, slot, wb_reg
    localparam row_t ROWS [NUM_ROWS] = '{
        // full word fill, both cores at once to use up credits
        '{1'b0, 2'd0, 1'b1, 4'b1111, 2'd0, 4'd0},
        '{1'b1, 2'd0, 1'b1, 4'b1111, 2'd0, 4'd0},
        '{1'b0, 2'd1, 1'b1, 4'b1111, 2'd1, 4'd0},
        '{1'b1, 2'd1, 1'b1, 4'b1111, 2'd1, 4'd0},
        '{1'b0, 2'd2, 1'b1, 4'b1111, 2'd2, 4'd0},
        '{1'b1, 2'd2, 1'b1, 4'b1111, 2'd2, 4'd0},
        '{1'b0, 2'd3, 1'b1, 4'b1111, 2'd3, 4'd0},
        '{1'b1, 2'd3, 1'b1, 4'b1111, 2'd3, 4'd0},
        // mixed masked traffic
        '{1'b0, 2'd0, 1'b0, 4'b1111, 2'd0, 4'd5},
        '{1'b1, 2'd0, 1'b1, 4'b0010, 2'd0, 4'd0},
        '{1'b0, 2'd1, 1'b0, 4'b0011, 2'd1, 4'd6},
        '{1'b1, 2'd1, 1'b0, 4'b0010, 2'd0, 4'd9},
        '{1'b0, 2'd2, 1'b1, 4'b0001, 2'd2, 4'd0},
        '{1'b1, 2'd2, 1'b0, 4'b1000, 2'd1, 4'd10},
        '{1'b0, 2'd3, 1'b0, 4'b1100, 2'd2, 4'd7},
        '{1'b1, 2'd3, 1'b0, 4'b0011, 2'd2, 4'd11},
        '{1'b0, 2'd0, 1'b0, 4'b0100, 2'd3, 4'd8},
        '{1'b1, 2'd0, 1'b0, 4'b1111, 2'd3, 4'd12},
        '{1'b0, 2'd1, 1'b1, 4'b1000, 2'd3, 4'd0},
        '{1'b1, 2'd1, 1'b0, 4'b0001, 2'd0, 4'd13}
    };

    logic                     clk;
    logic                     rst;
    lsu_pkg::core_req_t       core_req_a;
    lsu_pkg::core_req_t       core_req_b;
    logic                     issue_a;
    logic                     issue_b;
    logic                     issue_ready_a;
    logic                     issue_ready_b;
    logic [`LSU_THREADS-1:0]  stall_a;
    logic [`LSU_THREADS-1:0]  stall_b;
    lsu_pkg::load_ret_t       load_ret_a;
    lsu_pkg::load_ret_t       load_ret_b;
    logic                     load_vld_a;
    logic                     load_vld_b;

    logic [31:0]              shadow [`LSU_MEM_WORDS];
    logic [`LSU_ADDR_W-1:0]   slot_addr [2][4];
    logic [31:0]              row_data [NUM_ROWS];
    lsu_pkg::load_ret_t       exp_a [$];
    lsu_pkg::load_ret_t       exp_b [$];
    int                       pending [2] = '{0, 0};
    int                       streak [2] = '{0, 0};
    int                       errors = 0;
    logic                     credit_stall_seen = 1'b0;
    logic [31:0]              rng = 32'hf805;

    lsu_subsystem lsu_subsystem_inst (
        .clk           (clk),
        .rst           (rst),
        .core_req_a    (core_req_a),
        .issue_a       (issue_a),
        .issue_ready_a (issue_ready_a),
        .stall_a       (stall_a),
        .load_ret_a    (load_ret_a),
        .load_vld_a    (load_vld_a),
        .core_req_b    (core_req_b),
        .issue_b       (issue_b),
        .issue_ready_b (issue_ready_b),
        .stall_b       (stall_b),
        .load_ret_b    (load_ret_b),
        .load_vld_b    (load_vld_b)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ******************************
    // helpers
    // ******************************

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // lowest selected byte moves to bit 0, width set by the number of bytes
    function automatic logic [31:0] expect_lanes(input logic [31:0] word, input logic [3:0] mask);
        int          lo;
        int          width;
        logic [31:0] shifted;
        lo = 0;
        for (int i = 3; i >= 0; i--)
            if (mask[i])
                lo = i;
        width   = $countones(mask) * 8;
        shifted = word >> (lo * 8);
        if (width == 32)
            return shifted;
        return shifted & ((32'd1 << width) - 1);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic fill_stimulus();
        for (int c = 0; c < 2; c++)
            for (int s = 0; s < 4; s++)
            begin
                rng = xorshift(rng);
                slot_addr[c][s] = `LSU_ADDR_W'({1'(c), rng[8:0]});
            end
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            rng = xorshift(rng);
            row_data[i] = rng;
        end
    endtask

    // shadow memory and expected loads follow issue order
    task automatic record_issue(input int core, input lsu_pkg::core_req_t cr);
        lsu_pkg::load_ret_t exp;
        pending[core]++;
        if (cr.wr)
        begin
            for (int i = 0; i < 4; i++)
                if (cr.mask[i])
                    shadow[cr.addr][i*8 +: 8] = cr.wdata[i*8 +: 8];
        end
        else
        begin
            exp.thread = cr.thread;
            exp.wb_reg = cr.wb_reg;
            exp.data   = expect_lanes(shadow[cr.addr], cr.mask);
            if (core == 0)
                exp_a.push_back(exp);
            else
                exp_b.push_back(exp);
        end
    endtask

    task automatic drive_core(input int core);
        row_t               r;
        lsu_pkg::core_req_t cr;
        logic               taken;
        logic [3:0]         stall_bits;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            r = ROWS[i];
            if (r.core == 1'(core))
            begin
                cr = '{thread: r.thread, wr: r.wr, mask: r.mask,
                       addr: slot_addr[core][r.slot], wdata: row_data[i], wb_reg: r.wb_reg};
                if (core == 0)
                begin
                    core_req_a = cr;
                    issue_a    = 1'b1;
                end
                else
                begin
                    core_req_b = cr;
                    issue_b    = 1'b1;
                end
                taken = 1'b0;
                while (!taken)
                begin
                    @(negedge clk);
                    if (core == 0)
                        taken = issue_ready_a && !stall_a[r.thread];
                    else
                        taken = issue_ready_b && !stall_b[r.thread];
                    @(posedge clk);
                    #2;
                end
                if (core == 0)
                    issue_a = 1'b0;
                else
                    issue_b = 1'b0;
                stall_bits = (core == 0) ? stall_a : stall_b;
                compare($sformatf("stall_%0d[%0d]", core, r.thread), stall_bits[r.thread], 1'b1);
                record_issue(core, cr);
            end
        end
    endtask

    task automatic check_load(input int core, input lsu_pkg::load_ret_t got, input logic [3:0] st);
        lsu_pkg::load_ret_t exp;
        if ((core == 0 && exp_a.size() == 0) || (core == 1 && exp_b.size() == 0))
        begin
            errors++;
            $display("core %0d returned a load that it never issued at %0t", core, $time);
        end
        else
        begin
            if (core == 0)
                exp = exp_a.pop_front();
            else
                exp = exp_b.pop_front();
            compare($sformatf("load_ret_%0d.thread", core), got.thread, exp.thread);
            compare($sformatf("load_ret_%0d.wb_reg", core), got.wb_reg, exp.wb_reg);
            compare($sformatf("load_ret_%0d.data", core), got.data, exp.data);
            compare($sformatf("stall_%0d[%0d]", core, got.thread), st[got.thread], 1'b0);
        end
    endtask

    // grants in a row to one master while the other waits
    task automatic track_grant(input int m);
        pending[m]--;
        streak[m] = 0;
        if (pending[1 - m] > 0)
            streak[1 - m]++;
        if (streak[1 - m] > 2)
        begin
            errors++;
            $display("core %0d waited for %0d grants of the other core at %0t",
                     1 - m, streak[1 - m], $time);
        end
    endtask

    // requests still holding a buffer slot, the grant now on the bus was already popped
    function automatic int slots_in_use(input int m);
        int used;
        used = pending[m];
        if (lsu_subsystem_inst.mem_vld && int'(lsu_subsystem_inst.mem_req.master) == m)
            used--;
        return used;
    endfunction

    // ******************************
    // monitor, sampled mid cycle
    // ******************************

    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (load_vld_a)
                check_load(0, load_ret_a, stall_a);
            if (load_vld_b)
                check_load(1, load_ret_b, stall_b);
            compare("issue_ready_a", issue_ready_a, slots_in_use(0) < `LSU_CREDITS);
            compare("issue_ready_b", issue_ready_b, slots_in_use(1) < `LSU_CREDITS);
            if (!issue_ready_a || !issue_ready_b)
                credit_stall_seen = 1'b1;
            if (lsu_subsystem_inst.mem_vld)
                track_grant(int'(lsu_subsystem_inst.mem_req.master));
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with requests still open", WATCHDOG_CYCLES);
        $display("errors: %0d", errors);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        rst        = 1'b1;
        core_req_a = '0;
        core_req_b = '0;
        issue_a    = 1'b0;
        issue_b    = 1'b0;
        fill_stimulus();
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        compare("stall_a", stall_a, '0);
        compare("stall_b", stall_b, '0);
        compare("load_vld_a", load_vld_a, 1'b0);
        compare("load_vld_b", load_vld_b, 1'b0);
        compare("issue_ready_a", issue_ready_a, 1'b1);
        compare("issue_ready_b", issue_ready_b, 1'b1);
        @(posedge clk);
        #2;
        fork
            drive_core(0);
            drive_core(1);
        join
        while (exp_a.size() != 0 || exp_b.size() != 0 || stall_a != '0 || stall_b != '0)
            @(posedge clk);
        repeat (5) @(posedge clk);
        @(negedge clk);
        compare("issue_ready_a", issue_ready_a, 1'b1);
        compare("issue_ready_b", issue_ready_b, 1'b1);
        if (!credit_stall_seen)
        begin
            errors++;
            $display("issue_ready never dropped while both cores were busy");
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/credit_fifo.sv
logic/lsu_thread_port.sv
logic/mem_arbiter.sv
logic/data_mem.sv
logic/lsu_subsystem.sv
sim/lsu_assert.sv
sim/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_subsystem

export_include_dirs:
  - logic

sources:
  - files:
      - logic/lsu_pkg.sv
      - logic/credit_fifo.sv
      - logic/lsu_thread_port.sv
      - logic/mem_arbiter.sv
      - logic/data_mem.sv
      - logic/lsu_subsystem.sv
  - target: test
    files:
      - sim/lsu_assert.sv
      - sim/lsu_tb.sv
